// ==== Makefile ====
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module mem2w_tb -f sources.f -o mem2w_sim

run: compile
	./obj_dir/mem2w_sim +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/mem2w_input.txt ====
// op wen wa_addr wa_data wb_addr wb_data ren ra_addr rb_addr exp_a exp_b
// op 1 one cycle, 2 random cycles (count in wen), 3 fill and read back, 0 end; exp = loc, data
3 0 00 0000 00 0000 0 00 00 00000 00000
1 3 05 1111 0a 2222 0 00 00 00000 00000
1 0 00 0000 00 0000 3 05 0a 11111 22222
1 3 04 3333 10 4444 0 00 00 00000 00000
1 0 00 0000 00 0000 3 04 10 03333 44444
1 3 0d 5555 11 6666 0 00 00 00000 00000
1 0 00 0000 00 0000 3 10 11 04444 46666
1 1 11 7777 00 0000 3 0d 10 15555 04444
1 0 00 0000 00 0000 3 11 10 17777 04444
1 1 05 8888 00 0000 3 05 0a 11111 22222
1 0 00 0000 00 0000 1 05 00 18888 00000
2 c8 00 0000 00 0000 0 00 00 00000 00000
0

// ==== dv/mem2w_props.sv ====
`timescale 1ns/1ps

module mem2w_props import mem2w_pkg::*; #(
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int NUM_ROWS = DEF_NUM_ROWS,
  localparam int BW = $clog2(NUM_BANKS),
  localparam int RW = $clog2(NUM_ROWS)
) (
  input logic clk,
  input logic rst,
  input logic wr_en_a,
  input logic wr_en_b,
  input logic [BW+RW-1:0] wr_addr_a,
  input logic [BW+RW-1:0] wr_addr_b,
  input logic clash,
  input logic evict,
  input logic [RW-1:0] row_b_q,
  input logic [BW-1:0] old_bank,
  input logic [NUM_ROWS-1:0] map_vld
);

  int fails = 0;

  // the two write ports never carry the same address in one cycle
  assert property (@(posedge clk) disable iff (rst)
    !(wr_en_a && wr_en_b && (wr_addr_a == wr_addr_b)))
  else begin
    $error("both write ports addressed the same word in one cycle");
    fails++;
  end

  assert property (@(posedge clk) disable iff (rst)
    clash |=> map_vld[$past(row_b_q)])
  else begin
    $error("cache write did not leave its row's map entry valid");
    fails++;
  end

  // an eviction needs last cycle's writes to share a bank and a cached word of another bank
  assert property (@(posedge clk) disable iff (rst)
    evict |-> ($past(wr_en_a) && $past(wr_en_b)
               && ($past(wr_addr_a[BW-1:0]) == $past(wr_addr_b[BW-1:0]))
               && map_vld[$past(wr_addr_b[BW+RW-1:BW])]
               && (old_bank != $past(wr_addr_b[BW-1:0]))))
  else begin
    $error("eviction without a same-bank write pair and a valid map entry for another bank");
    fails++;
  end

endmodule

bind write_steer mem2w_props #(
  .NUM_BANKS(NUM_BANKS),
  .NUM_ROWS(NUM_ROWS)
) mem2w_props_i (
  .clk, .rst, .wr_en_a, .wr_en_b, .wr_addr_a, .wr_addr_b,
  .clash, .evict, .row_b_q, .old_bank, .map_vld
);

// ==== dv/mem2w_tb.sv ====
`timescale 1ns/1ps

module mem2w_tb;

  localparam int WIDTH = 16;
  localparam int NUM_BANKS = 4;
  localparam int NUM_ROWS = 8;
  localparam int BW = 2;
  localparam int AW = 5;
  localparam int LW = 3;
  localparam int TOKENS = 11;

  logic clk = 1'b0;
  logic rst;
  logic wr_en_a;
  logic [AW-1:0] wr_addr_a;
  logic [WIDTH-1:0] wr_data_a;
  logic wr_en_b;
  logic [AW-1:0] wr_addr_b;
  logic [WIDTH-1:0] wr_data_b;
  logic rd_en_a;
  logic [AW-1:0] rd_addr_a;
  logic rd_en_b;
  logic [AW-1:0] rd_addr_b;
  logic rd_vld_a;
  logic [WIDTH-1:0] rd_data_a;
  logic [LW-1:0] rd_loc_a;
  logic rd_vld_b;
  logic [WIDTH-1:0] rd_data_b;
  logic [LW-1:0] rd_loc_b;

  logic [31:0] cmds [0:TOKENS*32-1];
  logic [WIDTH-1:0] words [2**AW];
  logic map_vld [NUM_ROWS];
  logic [BW-1:0] map_bank [NUM_ROWS];
  // expected read results sit in a slot picked by the issue cycle
  logic exp_vld [2][4];
  logic [WIDTH-1:0] exp_data [2][4];
  logic [LW-1:0] exp_loc [2][4];
  int cyc = 0;
  int checks = 0;
  int errors = 0;
  int limit_cycles = 0;

  mem2w_top #(.WIDTH(WIDTH), .NUM_BANKS(NUM_BANKS), .NUM_ROWS(NUM_ROWS)) mem2w_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [LW-1:0] loc_of(input logic [AW-1:0] addr);
    if (map_vld[addr[AW-1:BW]] && (map_bank[addr[AW-1:BW]] == addr[BW-1:0])) begin
      return LW'(NUM_BANKS);
    end
    return {1'b0, addr[BW-1:0]};
  endfunction

  // at commit a same-bank pair sends b to the cache row
  task automatic commit(input logic [1:0] wen, input logic [AW-1:0] wa,
                        input logic [WIDTH-1:0] da, input logic [AW-1:0] wb,
                        input logic [WIDTH-1:0] db);
    logic clash;
    logic drop_a;
    logic drop_b;
    clash = wen[0] && wen[1] && (wa[BW-1:0] == wb[BW-1:0]);
    drop_a = wen[0] && (loc_of(wa) == LW'(NUM_BANKS));
    drop_b = wen[1] && !clash && (loc_of(wb) == LW'(NUM_BANKS));
    if (drop_a) map_vld[wa[AW-1:BW]] = 1'b0;
    if (drop_b) map_vld[wb[AW-1:BW]] = 1'b0;
    if (clash) begin
      map_vld[wb[AW-1:BW]] = 1'b1;
      map_bank[wb[AW-1:BW]] = wb[BW-1:0];
    end
    if (wen[0]) words[wa] = da;
    if (wen[1]) words[wb] = db;
  endtask

  task automatic step(input logic [1:0] wen, input logic [AW-1:0] wa,
                      input logic [WIDTH-1:0] da, input logic [AW-1:0] wb,
                      input logic [WIDTH-1:0] db, input logic [1:0] ren,
                      input logic [AW-1:0] ra, input logic [AW-1:0] rb,
                      input logic use_exp, input logic [19:0] xa, input logic [19:0] xb);
    int s;
    @(posedge clk);
    #5;
    s = cyc & 3;
    {wr_en_b, wr_en_a} = wen;
    wr_addr_a = wa;
    wr_data_a = da;
    wr_addr_b = wb;
    wr_data_b = db;
    {rd_en_b, rd_en_a} = ren;
    rd_addr_a = ra;
    rd_addr_b = rb;
    // reads see only writes from earlier cycles, so predict before commit
    exp_vld[0][s] = ren[0];
    exp_vld[1][s] = ren[1];
    exp_data[0][s] = use_exp ? xa[15:0] : words[ra];
    exp_loc[0][s] = use_exp ? xa[18:16] : loc_of(ra);
    exp_data[1][s] = use_exp ? xb[15:0] : words[rb];
    exp_loc[1][s] = use_exp ? xb[18:16] : loc_of(rb);
    commit(wen, wa, da, wb, db);
  endtask

  task automatic run_command(input int base);
    logic [AW-1:0] wa;
    logic [AW-1:0] wb;
    if (cmds[base] == 1) begin
      step(cmds[base+1][1:0], cmds[base+2][AW-1:0], cmds[base+3][WIDTH-1:0],
           cmds[base+4][AW-1:0], cmds[base+5][WIDTH-1:0], cmds[base+6][1:0],
           cmds[base+7][AW-1:0], cmds[base+8][AW-1:0], 1'b1,
           cmds[base+9][19:0], cmds[base+10][19:0]);
    end else if (cmds[base] == 3) begin
      for (int i = 0; i < 2**AW; i++) begin
        step(2'b01, AW'(i), WIDTH'($urandom), '0, '0, 2'b00, '0, '0, 1'b0, '0, '0);
      end
      for (int i = 0; i < 2**AW; i++) begin
        step(2'b00, '0, '0, '0, '0, 2'b11, AW'(i), AW'(31 - i), 1'b0, '0, '0);
      end
    end else begin
      for (int i = 0; i < int'(cmds[base+1]); i++) begin
        wa = AW'($urandom);
        wb = AW'($urandom);
        // same bank, other row, so an equal pair still makes a clash
        if (wb == wa) wb = wa + AW'(4);
        step(2'($urandom), wa, WIDTH'($urandom), wb, WIDTH'($urandom), 2'($urandom),
             AW'($urandom), AW'($urandom), 1'b0, '0, '0);
      end
    end
  endtask

  task automatic check_port(input int p, input logic vld, input logic [WIDTH-1:0] data,
                            input logic [LW-1:0] loc);
    int s;
    string pn;
    s = (cyc - 2) & 3;
    pn = (p == 0) ? "a" : "b";
    assert (vld == exp_vld[p][s]) else begin
      errors++;
      $display("FAIL rd_vld_%s: got %h expected %h", pn, vld, exp_vld[p][s]);
    end
    if (vld && exp_vld[p][s]) begin
      checks++;
      assert (data === exp_data[p][s]) else begin
        errors++;
        $display("FAIL rd_data_%s: got %h expected %h", pn, data, exp_data[p][s]);
      end
      assert (loc === exp_loc[p][s]) else begin
        errors++;
        $display("FAIL rd_loc_%s: got %h expected %h", pn, loc, exp_loc[p][s]);
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      check_port(0, rd_vld_a, rd_data_a, rd_loc_a);
      check_port(1, rd_vld_b, rd_data_b, rd_loc_b);
    end
  end

  initial begin
    int n;
    int total;
    int props_fails;
    void'($urandom(35));
    $readmemh("dv/mem2w_input.txt", cmds);
    {wr_en_a, wr_addr_a, wr_data_a, wr_en_b, wr_addr_b, wr_data_b} = '0;
    {rd_en_a, rd_addr_a, rd_en_b, rd_addr_b} = '0;
    rst = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) map_vld[i] = 1'b0;
    for (int i = 0; i < 8; i++) exp_vld[i / 4][i % 4] = 1'b0;
    n = 0;
    total = 16 + 4;
    while (cmds[n * TOKENS] != 0) begin
      if (cmds[n * TOKENS] == 2) total += int'(cmds[n * TOKENS + 1]);
      else if (cmds[n * TOKENS] == 3) total += 2 * (2**AW);
      else total += 1;
      n++;
    end
    limit_cycles = total;
    repeat (16) @(posedge clk);
    #5 rst = 1'b0;
    for (int k = 0; k < n; k++) run_command(k * TOKENS);
    // let the last reads drain out of the pipeline
    repeat (4) step(2'b00, '0, '0, '0, '0, 2'b00, '0, '0, 1'b0, '0, '0);
    props_fails = mem2w_top_i.write_steer_i.mem2w_props_i.fails;
    errors += props_fails;
    $display("reads checked %0d, errors %0d, assertion failures %0d",
             checks, errors, props_fails);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    #((limit_cycles + 40) * 100);
    $display("watchdog expired before all commands completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== logic/bank_array.sv ====
`timescale 1ns/1ps

module bank_array import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int NUM_ROWS = DEF_NUM_ROWS
) (
  input logic clk,
  bank_wr_if.mem bw,
  lookup_if.bank lu
);

  logic [WIDTH-1:0] mem [NUM_BANKS][NUM_ROWS];

  // each bank takes at most one write per cycle
  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    always_ff @(posedge clk) begin
      if (bw.en[k]) begin
        mem[k][bw.row[k]] <= bw.data[k];
      end
    end
  end

  // reads are combinational, the request is already registered upstream
  for (genvar i = 0; i < 2; i++) begin : g_rd
    assign lu.bank_data[i] = mem[lu.rd_bank[i]][lu.rd_row[i]];
  end

endmodule

// ==== logic/mem2w_ifs.sv ====
`timescale 1ns/1ps

// one write slot per bank
interface bank_wr_if import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int NUM_ROWS = DEF_NUM_ROWS
);
  logic [NUM_BANKS-1:0] en;
  logic [NUM_BANKS-1:0][$clog2(NUM_ROWS)-1:0] row;
  logic [NUM_BANKS-1:0][WIDTH-1:0] data;

  modport drv (output en, row, data);
  modport mem (input en, row, data);
endinterface

interface cache_if import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_ROWS = DEF_NUM_ROWS
);
  logic wr_en;
  logic [$clog2(NUM_ROWS)-1:0] wr_row;
  logic [WIDTH-1:0] wr_data;
  // peek shows the word that a clash may have to evict
  logic [$clog2(NUM_ROWS)-1:0] peek_row;
  logic [WIDTH-1:0] peek_data;

  modport ctl (output wr_en, wr_row, wr_data, peek_row, input peek_data);
  modport mem (input wr_en, wr_row, wr_data, peek_row, output peek_data);
endinterface

// index 0 is read port a, index 1 is read port b
interface lookup_if import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int NUM_ROWS = DEF_NUM_ROWS
);
  logic [1:0][$clog2(NUM_ROWS)-1:0] rd_row;
  logic [1:0][$clog2(NUM_BANKS)-1:0] rd_bank;
  logic [1:0][WIDTH-1:0] bank_data;
  logic [1:0][WIDTH-1:0] cache_data;
  logic [1:0] map_vld;
  logic [1:0][$clog2(NUM_BANKS)-1:0] map_bank;

  modport req (output rd_row, rd_bank, input bank_data, cache_data, map_vld, map_bank);
  modport bank (input rd_row, rd_bank, output bank_data);
  modport cache (input rd_row, output cache_data);
  modport map (input rd_row, output map_vld, map_bank);
endinterface

// ==== logic/mem2w_pkg.sv ====
package mem2w_pkg;

  localparam int DEF_WIDTH = 16;
  localparam int DEF_NUM_BANKS = 4;
  localparam int DEF_NUM_ROWS = 8;
  localparam int RD_LATENCY = 2;

  // bank number sits in the low bits of a word address
  function automatic logic [31:0] addr_bank(logic [31:0] addr, int unsigned bank_bits);
    return addr & ((32'd1 << bank_bits) - 32'd1);
  endfunction

  function automatic logic [31:0] addr_row(logic [31:0] addr, int unsigned bank_bits);
    return addr >> bank_bits;
  endfunction

endpackage

// ==== logic/mem2w_top.sv ====
`timescale 1ns/1ps

module mem2w_top import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int NUM_ROWS = DEF_NUM_ROWS,
  localparam int AW = $clog2(NUM_BANKS) + $clog2(NUM_ROWS),
  localparam int LW = $clog2(NUM_BANKS + 1)
) (
  input  logic clk,
  input  logic rst,
  input  logic wr_en_a,
  input  logic [AW-1:0] wr_addr_a,
  input  logic [WIDTH-1:0] wr_data_a,
  input  logic wr_en_b,
  input  logic [AW-1:0] wr_addr_b,
  input  logic [WIDTH-1:0] wr_data_b,
  input  logic rd_en_a,
  input  logic [AW-1:0] rd_addr_a,
  input  logic rd_en_b,
  input  logic [AW-1:0] rd_addr_b,
  output logic rd_vld_a,
  output logic [WIDTH-1:0] rd_data_a,
  output logic [LW-1:0] rd_loc_a,
  output logic rd_vld_b,
  output logic [WIDTH-1:0] rd_data_b,
  output logic [LW-1:0] rd_loc_b
);

  bank_wr_if #(.WIDTH(WIDTH), .NUM_BANKS(NUM_BANKS), .NUM_ROWS(NUM_ROWS)) bank_wr ();
  cache_if #(.WIDTH(WIDTH), .NUM_ROWS(NUM_ROWS)) cache ();
  lookup_if #(.WIDTH(WIDTH), .NUM_BANKS(NUM_BANKS), .NUM_ROWS(NUM_ROWS)) lookup ();

  write_steer #(.WIDTH(WIDTH), .NUM_BANKS(NUM_BANKS), .NUM_ROWS(NUM_ROWS)) write_steer_i (
    .clk(clk), .rst(rst),
    .wr_en_a(wr_en_a), .wr_addr_a(wr_addr_a), .wr_data_a(wr_data_a),
    .wr_en_b(wr_en_b), .wr_addr_b(wr_addr_b), .wr_data_b(wr_data_b),
    .bw(bank_wr.drv), .cw(cache.ctl), .lu(lookup.map)
  );

  bank_array #(.WIDTH(WIDTH), .NUM_BANKS(NUM_BANKS), .NUM_ROWS(NUM_ROWS)) bank_array_i (
    .clk(clk), .bw(bank_wr.mem), .lu(lookup.bank)
  );

  pivot_cache #(.WIDTH(WIDTH), .NUM_ROWS(NUM_ROWS)) pivot_cache_i (
    .clk(clk), .cw(cache.mem), .lu(lookup.cache)
  );

  read_merge #(.WIDTH(WIDTH), .NUM_BANKS(NUM_BANKS), .NUM_ROWS(NUM_ROWS)) read_merge_i (
    .clk(clk), .rst(rst),
    .rd_en_a(rd_en_a), .rd_addr_a(rd_addr_a),
    .rd_en_b(rd_en_b), .rd_addr_b(rd_addr_b),
    .lu(lookup.req),
    .rd_vld_a(rd_vld_a), .rd_data_a(rd_data_a), .rd_loc_a(rd_loc_a),
    .rd_vld_b(rd_vld_b), .rd_data_b(rd_data_b), .rd_loc_b(rd_loc_b)
  );

endmodule

// ==== logic/pivot_cache.sv ====
`timescale 1ns/1ps

module pivot_cache import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_ROWS = DEF_NUM_ROWS
) (
  input logic clk,
  cache_if.mem cw,
  lookup_if.cache lu
);

  logic [WIDTH-1:0] mem [NUM_ROWS];

  always_ff @(posedge clk) begin
    if (cw.wr_en) begin
      mem[cw.wr_row] <= cw.wr_data;
    end
  end

  // peek returns the word before this cycle's write lands
  assign cw.peek_data = mem[cw.peek_row];

  for (genvar i = 0; i < 2; i++) begin : g_rd
    assign lu.cache_data[i] = mem[lu.rd_row[i]];
  end

endmodule

// ==== logic/read_merge.sv ====
`timescale 1ns/1ps

module read_merge import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int NUM_ROWS = DEF_NUM_ROWS,
  localparam int BW = $clog2(NUM_BANKS),
  localparam int RW = $clog2(NUM_ROWS),
  localparam int AW = BW + RW,
  localparam int LW = $clog2(NUM_BANKS + 1)
) (
  input  logic clk,
  input  logic rst,
  input  logic rd_en_a,
  input  logic [AW-1:0] rd_addr_a,
  input  logic rd_en_b,
  input  logic [AW-1:0] rd_addr_b,
  lookup_if.req lu,
  output logic rd_vld_a,
  output logic [WIDTH-1:0] rd_data_a,
  output logic [LW-1:0] rd_loc_a,
  output logic rd_vld_b,
  output logic [WIDTH-1:0] rd_data_b,
  output logic [LW-1:0] rd_loc_b
);

  logic [1:0] en_in;
  logic [AW-1:0] addr_in [2];
  logic [RD_LATENCY-1:0] vld_pipe [2];
  logic [BW-1:0] bank_q [2];
  logic [RW-1:0] row_q [2];
  logic [1:0] hit;
  logic [WIDTH-1:0] data_q [2];
  logic [LW-1:0] loc_q [2];

  assign en_in = {rd_en_b, rd_en_a};
  assign addr_in[0] = rd_addr_a;
  assign addr_in[1] = rd_addr_b;

  for (genvar i = 0; i < 2; i++) begin : g_port
    always_ff @(posedge clk) begin
      if (rst) begin
        vld_pipe[i] <= '0;
      end else begin
        vld_pipe[i] <= {vld_pipe[i][RD_LATENCY-2:0], en_in[i]};
      end
    end

    always_ff @(posedge clk) begin
      if (en_in[i]) begin
        bank_q[i] <= BW'(addr_bank(32'(addr_in[i]), BW));
        row_q[i] <= RW'(addr_row(32'(addr_in[i]), BW));
      end
    end

    assign lu.rd_bank[i] = bank_q[i];
    assign lu.rd_row[i] = row_q[i];

    // the cache copy wins only if the map names this request's bank
    assign hit[i] = lu.map_vld[i] && (lu.map_bank[i] == bank_q[i]);

    always_ff @(posedge clk) begin
      if (vld_pipe[i][0]) begin
        data_q[i] <= hit[i] ? lu.cache_data[i] : lu.bank_data[i];
        loc_q[i] <= hit[i] ? LW'(NUM_BANKS) : LW'(bank_q[i]);
      end
    end
  end

  assign rd_vld_a = vld_pipe[0][RD_LATENCY-1];
  assign rd_data_a = data_q[0];
  assign rd_loc_a = loc_q[0];
  assign rd_vld_b = vld_pipe[1][RD_LATENCY-1];
  assign rd_data_b = data_q[1];
  assign rd_loc_b = loc_q[1];

endmodule

// ==== logic/write_steer.sv ====
`timescale 1ns/1ps

module write_steer import mem2w_pkg::*; #(
  parameter int WIDTH = DEF_WIDTH,
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int NUM_ROWS = DEF_NUM_ROWS,
  localparam int BW = $clog2(NUM_BANKS),
  localparam int RW = $clog2(NUM_ROWS),
  localparam int AW = BW + RW
) (
  input  logic clk,
  input  logic rst,
  input  logic wr_en_a,
  input  logic [AW-1:0] wr_addr_a,
  input  logic [WIDTH-1:0] wr_data_a,
  input  logic wr_en_b,
  input  logic [AW-1:0] wr_addr_b,
  input  logic [WIDTH-1:0] wr_data_b,
  bank_wr_if.drv bw,
  cache_if.ctl cw,
  lookup_if.map lu
);

  logic en_a_q;
  logic en_b_q;
  logic [BW-1:0] bank_a_q;
  logic [BW-1:0] bank_b_q;
  logic [RW-1:0] row_a_q;
  logic [RW-1:0] row_b_q;
  logic [WIDTH-1:0] data_a_q;
  logic [WIDTH-1:0] data_b_q;

  // a valid map entry means the cache holds that row's word for bank map_bank
  logic [NUM_ROWS-1:0] map_vld;
  logic [BW-1:0] map_bank [NUM_ROWS];

  logic clash;
  logic evict;
  logic clr_a;
  logic clr_b;
  logic [BW-1:0] old_bank;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_a_q <= 1'b0;
      en_b_q <= 1'b0;
    end else begin
      en_a_q <= wr_en_a;
      en_b_q <= wr_en_b;
    end
  end

  always_ff @(posedge clk) begin
    bank_a_q <= BW'(addr_bank(32'(wr_addr_a), BW));
    row_a_q <= RW'(addr_row(32'(wr_addr_a), BW));
    data_a_q <= wr_data_a;
    bank_b_q <= BW'(addr_bank(32'(wr_addr_b), BW));
    row_b_q <= RW'(addr_row(32'(wr_addr_b), BW));
    data_b_q <= wr_data_b;
  end

  assign clash = en_a_q && en_b_q && (bank_a_q == bank_b_q);
  assign old_bank = map_bank[row_b_q];
  // the old bank differs from b's bank, so its write slot is idle this cycle
  assign evict = clash && map_vld[row_b_q] && (old_bank != bank_b_q);
  assign clr_a = en_a_q && map_vld[row_a_q] && (map_bank[row_a_q] == bank_a_q);
  assign clr_b = en_b_q && !clash && map_vld[row_b_q] && (old_bank == bank_b_q);

  assign cw.wr_en = clash;
  assign cw.wr_row = row_b_q;
  assign cw.wr_data = data_b_q;
  assign cw.peek_row = row_b_q;

  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      bw.en[k] = 1'b0;
      bw.row[k] = row_a_q;
      bw.data[k] = data_a_q;
      if (en_a_q && (bank_a_q == BW'(k))) begin
        bw.en[k] = 1'b1;
      end else if (en_b_q && !clash && (bank_b_q == BW'(k))) begin
        bw.en[k] = 1'b1;
        bw.row[k] = row_b_q;
        bw.data[k] = data_b_q;
      end else if (evict && (old_bank == BW'(k))) begin
        bw.en[k] = 1'b1;
        bw.row[k] = row_b_q;
        bw.data[k] = cw.peek_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      map_vld <= '0;
    end else begin
      if (clr_a) begin
        map_vld[row_a_q] <= 1'b0;
      end
      if (clr_b) begin
        map_vld[row_b_q] <= 1'b0;
      end
      if (clash) begin
        map_vld[row_b_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clash) begin
      map_bank[row_b_q] <= bank_b_q;
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_map_rd
    assign lu.map_vld[i] = map_vld[lu.rd_row[i]];
    assign lu.map_bank[i] = map_bank[lu.rd_row[i]];
  end

endmodule

// ==== sources.f ====
logic/mem2w_pkg.sv
logic/mem2w_ifs.sv
logic/write_steer.sv
logic/bank_array.sv
logic/pivot_cache.sv
logic/read_merge.sv
logic/mem2w_top.sv
dv/mem2w_props.sv
dv/mem2w_tb.sv
